/* logic/usbPePkg.sv */
package usbPePkg;

    // ==================================================
    // Sizes
    // ==================================================

    // Endpoint count including endpoint 0
    localparam int EP_COUNT = 4;
    localparam int EP_SEL_WID = 2;
    // Endpoint field as carried in a token packet
    localparam int TOKEN_EP_WID = 4;
    localparam int ADDR_WID = 7;

    // 48 MHz clocks per 12 MHz bit time
    localparam int TICK_DIV = 4;
    localparam int TICK_CNT_WID = $clog2(TICK_DIV);
    // Bit times from token end until the data packet has to start
    localparam int TIMEOUT_TICKS = 18;
    localparam int TIMEOUT_CNT_WID = $clog2(TIMEOUT_TICKS);

    // ==================================================
    // Encodings
    // ==================================================

    // Low nibble of the PID byte, the high nibble is its complement
    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_SETUP = 4'b1101,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010
    } pidE;

    // Handshake requested from the transmitter
    typedef enum logic {
        HS_ACK = 1'b0,
        HS_NAK = 1'b1
    } handshakeE;

    typedef enum logic [2:0] {
        IDLE,
        AWAIT_DATA,
        RECEIVE,
        COMMIT,
        HANDSHAKE
    } txnStateE;

    // ==================================================
    // Bundles
    // ==================================================

    typedef struct packed {
        pidE                     pid;
        logic [ADDR_WID-1:0]     addr;
        logic [TOKEN_EP_WID-1:0] ep;
    } tokenT;

    // One byte towards the selected endpoint
    typedef struct packed {
        logic                  valid;
        logic [EP_SEL_WID-1:0] ep;
        logic [7:0]            data;
    } epWriteT;

    // Closes the running endpoint transaction
    typedef struct packed {
        logic                  done;
        logic                  success;
        logic [EP_SEL_WID-1:0] ep;
    } epCommitT;

    // PID byte carries its own complement as a check field
    function automatic logic pidCheckOk(logic [7:0] pidByte);
        return pidByte[7:4] == ~pidByte[3:0];
    endfunction

endpackage

/* logic/tokenCapture.sv */
`timescale 1ns/1ps

module tokenCapture import usbPePkg::*; (
    input  logic       clk48_i,
    input  logic       rst_i,

    // Accepted receive bytes
    input  logic [7:0] rxByte_i,
    input  logic       rxTake_i,
    input  logic       rxLast_i,

    // Decoded token, valid for one cycle
    output logic       tokenValid_o,
    output tokenT      token_o
);

    // Buffer for the first three bytes of a packet
    logic [2:0][7:0] byteBuf;
    // Position of the next byte, 3 means the packet is too long for a token
    logic [1:0]      byteCnt;
    logic            isTokenPid;
    logic            tokenEnd;

    // ==================================================
    // PID check on the first buffered byte
    // ==================================================

    always_comb begin
        isTokenPid = 1'b0;
        if (pidCheckOk(byteBuf[0])) begin
            case (byteBuf[0][3:0])
                PID_OUT, PID_IN, PID_SETUP: isTokenPid = 1'b1;
                default:                    isTokenPid = 1'b0;
            endcase
        end
    end

    // Last byte arrives as the third byte of the packet
    assign tokenEnd = rxTake_i && rxLast_i && (byteCnt == 2'd2) && isTokenPid;

    // ==================================================
    // Byte counter and valid pulse
    // ==================================================

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            byteCnt      <= 2'd0;
            tokenValid_o <= 1'b0;
        end else begin
            // Pulse shows up one cycle after the last byte
            tokenValid_o <= tokenEnd;
            if (rxTake_i) begin
                if (rxLast_i) begin
                    byteCnt <= 2'd0;
                end else if (byteCnt != 2'd3) begin
                    // Saturate so long packets never look like tokens
                    byteCnt <= byteCnt + 2'd1;
                end
            end
        end
    end

    // Byte storage
    always_ff @(posedge clk48_i) begin
        if (rxTake_i && (byteCnt != 2'd3)) begin
            byteBuf[byteCnt] <= rxByte_i;
        end
    end

    // ==================================================
    // Field decode
    // ==================================================

    // Buffer is stable in the valid cycle since the engine blocks the next byte
    assign token_o.pid  = pidE'(byteBuf[0][3:0]);
    assign token_o.addr = byteBuf[1][ADDR_WID-1:0];
    // Endpoint bit 0 sits at the top of byte 1, the rest at the bottom of byte 2
    assign token_o.ep   = {byteBuf[2][2:0], byteBuf[1][7]};

endmodule

/* logic/packetTimer.sv */
`timescale 1ns/1ps

module packetTimer import usbPePkg::*; (
    input  logic clk48_i,
    input  logic rst_i,

    // One-cycle start at token end
    input  logic start_i,
    // Bus activity level from the frontend
    input  logic gotSignal_i,
    output logic timeout_o
);

    logic [TICK_CNT_WID-1:0]    tickCnt;
    logic [TIMEOUT_CNT_WID-1:0] waitCnt;
    logic                       running;
    logic                       gotSignalQ;
    logic                       tick;
    logic                       signalRise;

    // One bit time every TICK_DIV clocks
    assign tick = (tickCnt == TICK_CNT_WID'(TICK_DIV - 1));
    assign signalRise = gotSignal_i && !gotSignalQ;

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            tickCnt    <= '0;
            waitCnt    <= '0;
            running    <= 1'b0;
            gotSignalQ <= 1'b0;
            timeout_o  <= 1'b0;
        end else begin
            gotSignalQ <= gotSignal_i;
            timeout_o  <= 1'b0;
            // Divider wraps on its own
            tickCnt    <= tick ? '0 : tickCnt + 1'b1;
            if (start_i) begin
                // Restart aligns the divider with the token end
                tickCnt <= '0;
                waitCnt <= '0;
                running <= 1'b1;
            end else if (running) begin
                if (signalRise) begin
                    // Host started its packet in time
                    running <= 1'b0;
                end else if (tick) begin
                    if (waitCnt == TIMEOUT_CNT_WID'(TIMEOUT_TICKS - 1)) begin
                        running   <= 1'b0;
                        timeout_o <= 1'b1;
                    end else begin
                        waitCnt <= waitCnt + 1'b1;
                    end
                end
            end
        end
    end

endmodule

/* logic/transactionEngine.sv */
`timescale 1ns/1ps

module transactionEngine import usbPePkg::*; (
    input  logic                clk48_i,
    input  logic                rst_i,

    // Token from tokenCapture
    input  logic                tokenValid_i,
    input  tokenT               token_i,

    // Wait timer
    input  logic                timeout_i,
    output logic                timerStart_o,

    // Receive byte stream
    input  logic [7:0]          rxData_i,
    input  logic                rxDataValid_i,
    input  logic                rxIsLastByte_i,
    input  logic                keepPacket_i,
    output logic                rxAcceptNewData_o,
    output logic                rxTake_o,

    // Device state
    input  logic [ADDR_WID-1:0] deviceAddr_i,
    input  logic [EP_COUNT-1:0] epFull_i,

    // Endpoint bus
    output epWriteT             epWrite_o,
    output epCommitT            epCommit_o,

    // Handshake request
    output logic                txReqSendPacket_o,
    output handshakeE           txHandshake_o,
    input  logic                txAcceptNewData_i
);

    txnStateE              state;
    // Byte taken in the previous cycle was a last byte
    logic                  lastSeenQ;
    logic                  writeValidQ;
    logic [7:0]            writeDataQ;

    // Transaction context latched with the token
    logic [EP_SEL_WID-1:0] epSel;
    logic                  epWasFull;
    // Receive status of the data packet
    logic                  dataPidOk;
    logic                  keepQ;
    handshakeE             handshakeQ;

    logic                  tokenIsOut;
    logic                  tokenAccept;
    logic                  commitSuccess;

    // ==================================================
    // Token check and receive handshake
    // ==================================================

    assign tokenIsOut = (token_i.pid == PID_OUT) || (token_i.pid == PID_SETUP);
    assign tokenAccept = (state == IDLE) && tokenValid_i && tokenIsOut
        && (token_i.addr == deviceAddr_i)
        && (token_i.ep < TOKEN_EP_WID'(EP_COUNT));
    assign timerStart_o = tokenAccept;

    // Gap after every packet end, and no bytes while the handshake waits
    assign rxAcceptNewData_o = !lastSeenQ && (state != HANDSHAKE);
    assign rxTake_o = rxDataValid_i && rxAcceptNewData_o;

    // Good packet and a DATA PID in front
    assign commitSuccess = keepQ && dataPidOk;

    // ==================================================
    // State machine
    // ==================================================

    always_ff @(posedge clk48_i) begin
        if (rst_i) begin
            state       <= IDLE;
            lastSeenQ   <= 1'b0;
            writeValidQ <= 1'b0;
        end else begin
            lastSeenQ   <= rxTake_o && rxIsLastByte_i;
            // Payload bytes only, full endpoints get nothing
            writeValidQ <= (state == RECEIVE) && rxTake_o && !epWasFull;
            case (state)
                IDLE: begin
                    if (tokenAccept) begin
                        state <= AWAIT_DATA;
                    end
                end
                AWAIT_DATA: begin
                    if (timeout_i) begin
                        // Host never sent its data packet
                        state <= IDLE;
                    end else if (rxTake_o) begin
                        state <= rxIsLastByte_i ? COMMIT : RECEIVE;
                    end
                end
                RECEIVE: begin
                    if (rxTake_o && rxIsLastByte_i) begin
                        state <= COMMIT;
                    end
                end
                COMMIT: begin
                    // Receive error sends no handshake at all
                    state <= commitSuccess ? HANDSHAKE : IDLE;
                end
                HANDSHAKE: begin
                    if (txAcceptNewData_i) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Context and status registers
    always_ff @(posedge clk48_i) begin
        if (tokenAccept) begin
            epSel     <= token_i.ep[EP_SEL_WID-1:0];
            epWasFull <= epFull_i[token_i.ep[EP_SEL_WID-1:0]];
        end
        // First byte of the data packet is its PID
        if ((state == AWAIT_DATA) && rxTake_o) begin
            dataPidOk <= pidCheckOk(rxData_i)
                && ((rxData_i[3:0] == PID_DATA0) || (rxData_i[3:0] == PID_DATA1));
        end
        if (rxTake_o && rxIsLastByte_i) begin
            keepQ <= keepPacket_i;
        end
        if (rxTake_o) begin
            writeDataQ <= rxData_i;
        end
        if (state == COMMIT) begin
            // Full endpoint refuses the data but the packet itself was fine
            handshakeQ <= epWasFull ? HS_NAK : HS_ACK;
        end
    end

    // ==================================================
    // Outputs
    // ==================================================

    assign epWrite_o.valid = writeValidQ;
    assign epWrite_o.ep    = epSel;
    assign epWrite_o.data  = writeDataQ;

    // Commit lands one cycle after the last byte
    assign epCommit_o.done    = (state == COMMIT);
    assign epCommit_o.success = commitSuccess;
    assign epCommit_o.ep      = epSel;

    // Request held until the transmitter takes it
    assign txReqSendPacket_o = (state == HANDSHAKE);
    assign txHandshake_o     = handshakeQ;

endmodule

/* logic/usbPe.sv */
`timescale 1ns/1ps

module usbPe import usbPePkg::*; (
    input  logic                clk48_i,
    input  logic                rst_i,

    // Serial frontend receive side
    input  logic [7:0]          rxData_i,
    input  logic                rxDataValid_i,
    input  logic                rxIsLastByte_i,
    input  logic                keepPacket_i,
    output logic                rxAcceptNewData_o,
    input  logic                rxDPPLGotSignal_i,

    // Device state
    input  logic [ADDR_WID-1:0] deviceAddr_i,
    input  logic [EP_COUNT-1:0] epFull_i,

    // Shared endpoint bus
    output epWriteT             epWrite_o,
    output epCommitT            epCommit_o,

    // Transmitter handshake request
    output logic                txReqSendPacket_o,
    output handshakeE           txHandshake_o,
    input  logic                txAcceptNewData_i
);

    // Accepted byte strobe from the engine
    logic  rxTake;
    logic  tokenValid;
    tokenT token;
    logic  timerStart;
    logic  timeout;

    // ==================================================
    // Token recognition and wait timer side by side
    // ==================================================

    tokenCapture tokenCaptureInst (
        .clk48_i      (clk48_i),
        .rst_i        (rst_i),
        .rxByte_i     (rxData_i),
        .rxTake_i     (rxTake),
        .rxLast_i     (rxIsLastByte_i),
        .tokenValid_o (tokenValid),
        .token_o      (token)
    );

    packetTimer packetTimerInst (
        .clk48_i     (clk48_i),
        .rst_i       (rst_i),
        .start_i     (timerStart),
        .gotSignal_i (rxDPPLGotSignal_i),
        .timeout_o   (timeout)
    );

    // Transaction control
    transactionEngine transactionEngineInst (
        .clk48_i           (clk48_i),
        .rst_i             (rst_i),
        .tokenValid_i      (tokenValid),
        .token_i           (token),
        .timeout_i         (timeout),
        .timerStart_o      (timerStart),
        .rxData_i          (rxData_i),
        .rxDataValid_i     (rxDataValid_i),
        .rxIsLastByte_i    (rxIsLastByte_i),
        .keepPacket_i      (keepPacket_i),
        .rxAcceptNewData_o (rxAcceptNewData_o),
        .rxTake_o          (rxTake),
        .deviceAddr_i      (deviceAddr_i),
        .epFull_i          (epFull_i),
        .epWrite_o         (epWrite_o),
        .epCommit_o        (epCommit_o),
        .txReqSendPacket_o (txReqSendPacket_o),
        .txHandshake_o     (txHandshake_o),
        .txAcceptNewData_i (txAcceptNewData_i)
    );

endmodule

/* sim/usbPe_checker.sv */
`timescale 1ns/1ps

module usbPe_checker import usbPePkg::*; (
    input logic      clk48_i,
    input logic      rst_i,
    input logic      rxDataValid_i,
    input logic      rxIsLastByte_i,
    input logic      rxAccept_i,
    input epWriteT   epWrite_i,
    input logic      txReq_i,
    input handshakeE txHandshake_i,
    input logic      txAccept_i,
    input txnStateE  engineState_i
);

    // Failed assertions, summed into the testbench result
    int assertFails = 0;

    // Writes belong to an open transaction
    writeOutsideIdle: assert property (@(posedge clk48_i) disable iff (rst_i)
        epWrite_i.valid |-> (engineState_i != IDLE))
    else begin
        assertFails++;
        $error("Endpoint write strobe while the engine is idle");
    end

    // Request and its handshake hold until the transmitter takes them
    requestHeld: assert property (@(posedge clk48_i) disable iff (rst_i)
        txReq_i && !txAccept_i |=> txReq_i && $stable(txHandshake_i))
    else begin
        assertFails++;
        $error("Handshake request dropped or changed before it was accepted");
    end

    // Gap cycle after every last byte
    gapAfterLast: assert property (@(posedge clk48_i) disable iff (rst_i)
        rxDataValid_i && rxAccept_i && rxIsLastByte_i |=> !rxAccept_i)
    else begin
        assertFails++;
        $error("Receive accept high right after a last byte");
    end

endmodule

bind usbPe usbPe_checker checkerInst (
    .clk48_i       (clk48_i),
    .rst_i         (rst_i),
    .rxDataValid_i (rxDataValid_i),
    .rxIsLastByte_i(rxIsLastByte_i),
    .rxAccept_i    (rxAcceptNewData_o),
    .epWrite_i     (epWrite_o),
    .txReq_i       (txReqSendPacket_o),
    .txHandshake_i (txHandshake_o),
    .txAccept_i    (txAcceptNewData_i),
    .engineState_i (transactionEngineInst.state)
);

/* sim/usbPe_tb.sv */
`timescale 1ns/1ps

module usbPe_tb import usbPePkg::*; ();

    localparam int CLK_PERIOD = 40;
    // Words per record in the stimulus file
    localparam int REC_WORDS = 15;
    localparam int MAX_RECORDS = 32;
    localparam int MAX_DATA = 4;
    // Cycle budget per record sized for the silent-host record
    localparam int RECORD_CYCLES = 200;

    logic                  clk48_i = 1'b0;
    logic                  rst_i;
    logic [7:0]            rxData_i;
    logic                  rxDataValid_i;
    logic                  rxIsLastByte_i;
    logic                  keepPacket_i;
    logic                  rxAcceptNewData_o;
    logic                  rxDPPLGotSignal_i;
    logic [ADDR_WID-1:0]   deviceAddr_i;
    logic [EP_COUNT-1:0]   epFull_i;
    epWriteT               epWrite_o;
    epCommitT              epCommit_o;
    logic                  txReqSendPacket_o;
    handshakeE             txHandshake_o;
    logic                  txAcceptNewData_i;

    logic [7:0]            stim [MAX_RECORDS*REC_WORDS];
    logic [7:0]            pktBuf [$];
    // Payload and endpoint of the running record
    logic [7:0]            curBytes [MAX_DATA];
    logic [EP_SEL_WID-1:0] curEp;
    int                    recordCount = 0;
    int                    seed = 63;
    int                    hsHold;
    int                    holdCnt;
    int                    writeCount;
    int                    commitCount;
    int                    hsCount;
    epCommitT              lastCommit;
    handshakeE             lastHandshake;
    int                    errWrite = 0;
    int                    errCommit = 0;
    int                    errHandshake = 0;
    int                    errTotal;

    usbPe DUT (.*);

    always #(CLK_PERIOD/2) clk48_i = ~clk48_i;

    // ==================================================
    // Expected values and compare tasks
    // ==================================================

    // PID byte is the nibble with its complement on top
    function automatic logic [7:0] pidByte(input logic [3:0] pid);
        return {~pid, pid};
    endfunction

    function automatic epWriteT expectedWrite(input int idx);
        epWriteT want;
        want.valid = 1'b1;
        want.ep    = curEp;
        want.data  = curBytes[(idx < MAX_DATA) ? idx : MAX_DATA - 1];
        return want;
    endfunction

    task automatic checkWrite(input epWriteT got, input epWriteT want);
        if (got !== want) begin
            errWrite++;
            $display("Error at %0t ns: write got ep %0d data %h, expected ep %0d data %h",
                $time, got.ep, got.data, want.ep, want.data);
        end
    endtask

    task automatic checkCommit(input epCommitT got, input epCommitT want);
        if (got !== want) begin
            errCommit++;
            $display("Error at %0t ns: commit got success %b ep %0d, expected success %b ep %0d",
                $time, got.success, got.ep, want.success, want.ep);
        end
    endtask

    task automatic checkHandshake(input handshakeE got, input handshakeE want);
        if (got !== want) begin
            errHandshake++;
            $display("Error at %0t ns: handshake got %s, expected %s",
                $time, got.name(), want.name());
        end
    endtask

    // ==================================================
    // Bus driver
    // ==================================================

    // Sends pktBuf with random gaps while the bus activity level is high
    task automatic sendPacket(input logic keep);
        int i;
        rxDPPLGotSignal_i = 1'b1;
        for (i = 0; i < pktBuf.size(); i++) begin
            rxDataValid_i = 1'b0;
            repeat ($unsigned($random(seed)) % 3) @(negedge clk48_i);
            rxData_i       = pktBuf[i];
            rxDataValid_i  = 1'b1;
            rxIsLastByte_i = (i == pktBuf.size() - 1);
            keepPacket_i   = keep;
            // Hold the byte until the engine can take it
            while (!rxAcceptNewData_o) @(negedge clk48_i);
            @(negedge clk48_i);
        end
        rxDataValid_i     = 1'b0;
        rxIsLastByte_i    = 1'b0;
        keepPacket_i      = 1'b0;
        rxDPPLGotSignal_i = 1'b0;
    endtask

    task automatic runRecord(input int r);
        logic [7:0] f [REC_WORDS];
        int         i;
        epCommitT   wantCommit;
        for (i = 0; i < REC_WORDS; i++) begin
            f[i] = stim[r * REC_WORDS + i];
        end
        writeCount  = 0;
        commitCount = 0;
        hsCount     = 0;
        holdCnt     = 0;
        hsHold      = $unsigned($random(seed)) % 4;
        curEp       = f[2][EP_SEL_WID-1:0];
        for (i = 0; i < MAX_DATA; i++) begin
            curBytes[i] = f[5 + i];
        end
        epFull_i = f[10][EP_COUNT-1:0];
        // Token bytes are the PID, the address with endpoint bit 0 on top and endpoint bits 3..1
        pktBuf.delete();
        pktBuf.push_back(pidByte(f[0][3:0]));
        pktBuf.push_back({f[2][0], f[1][6:0]});
        pktBuf.push_back({5'b0, f[2][3:1]});
        sendPacket(1'b1);
        if (f[11] != 0) begin
            // Silent host well past the wait window
            repeat (TIMEOUT_TICKS * TICK_DIV + 16) @(negedge clk48_i);
        end else begin
            repeat (4 + $unsigned($random(seed)) % 8) @(negedge clk48_i);
            pktBuf.delete();
            pktBuf.push_back(pidByte(f[3][3:0]));
            for (i = 0; i < f[4]; i++) begin
                pktBuf.push_back(f[5 + i]);
            end
            sendPacket(f[9][0]);
            if (f[14] != 8'h0F) begin
                while (hsCount == 0) @(negedge clk48_i);
            end
            // Commit is due one cycle after the last byte
            repeat (4) @(negedge clk48_i);
        end
        if (writeCount != f[12]) begin
            errWrite++;
            $display("Error at %0t ns: record %0d gave %0d writes, expected %0d",
                $time, r, writeCount, f[12]);
        end
        if (commitCount != ((f[13] != 0) ? 1 : 0)) begin
            errCommit++;
            $display("Error at %0t ns: record %0d gave %0d commits", $time, r, commitCount);
        end else if (f[13] != 0) begin
            wantCommit.done    = 1'b1;
            wantCommit.success = (f[13] == 8'h01);
            wantCommit.ep      = curEp;
            checkCommit(lastCommit, wantCommit);
        end
        if (hsCount != ((f[14] != 8'h0F) ? 1 : 0)) begin
            errHandshake++;
            $display("Error at %0t ns: record %0d gave %0d handshakes", $time, r, hsCount);
        end else if (f[14] != 8'h0F) begin
            checkHandshake(lastHandshake, handshakeE'(f[14][0]));
        end
    endtask

    // ==================================================
    // Monitor and transmitter model
    // ==================================================

    always @(negedge clk48_i) begin
        if (!rst_i) begin
            if (epWrite_o.valid) begin
                checkWrite(epWrite_o, expectedWrite(writeCount));
                writeCount++;
            end
            if (epCommit_o.done) begin
                lastCommit = epCommit_o;
                commitCount++;
            end
            // Transmitter stays busy for hsHold cycles before it takes the request
            if (txAcceptNewData_i) begin
                txAcceptNewData_i = 1'b0;
            end else if (txReqSendPacket_o) begin
                if (holdCnt >= hsHold) begin
                    txAcceptNewData_i = 1'b1;
                    lastHandshake = txHandshake_o;
                    hsCount++;
                    holdCnt = 0;
                end else begin
                    holdCnt++;
                end
            end
        end
    end

    initial begin
        int r;
        rst_i             = 1'b1;
        rxData_i          = '0;
        rxDataValid_i     = 1'b0;
        rxIsLastByte_i    = 1'b0;
        keepPacket_i      = 1'b0;
        rxDPPLGotSignal_i = 1'b0;
        deviceAddr_i      = 7'h2A;
        epFull_i          = '0;
        txAcceptNewData_i = 1'b0;
        holdCnt           = 0;
        hsHold            = 0;
        // FF in the PID column marks the end of the records
        for (r = 0; r < MAX_RECORDS; r++) begin
            stim[r * REC_WORDS] = 8'hFF;
        end
        $readmemh("sim/usbPe_stim.txt", stim);
        while (recordCount < MAX_RECORDS && stim[recordCount * REC_WORDS] != 8'hFF) begin
            recordCount++;
        end
        repeat (5) @(posedge clk48_i);
        @(negedge clk48_i);
        rst_i = 1'b0;
        if (recordCount == 0) begin
            $display("No stimulus records could be read from sim/usbPe_stim.txt");
            $display("Checks failed");
        end else begin
            for (r = 0; r < recordCount; r++) begin
                runRecord(r);
            end
            repeat (4) @(negedge clk48_i);
            errTotal = errWrite + errCommit + errHandshake + DUT.checkerInst.assertFails;
            $display("Error counts: write %0d, commit %0d, handshake %0d, assertion %0d",
                errWrite, errCommit, errHandshake, DUT.checkerInst.assertFails);
            if (errTotal == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
        end
        $finish;
    end

    // Watchdog sized from the number of records
    initial begin
        wait (!rst_i);
        #((recordCount * RECORD_CYCLES + 20) * CLK_PERIOD);
        $display("Watchdog expired before all %0d records were done", recordCount);
        $display("Checks failed");
        $finish;
    end

endmodule

/* sim/usbPe_stim.txt */
// tokPid tokAddr tokEp dataPid nData d0 d1 d2 d3 keep epFull silent expWrites
// expCommit (0 none, 1 success, 2 failure) expHandshake (0 ACK, 1 NAK, 0F none)
01 2A 01 03 04 11 22 33 44 01 00 00 04 01 00
0D 2A 00 03 03 80 06 00 00 01 00 00 03 01 00
01 2A 03 0B 02 5A A5 00 00 01 08 00 00 01 01
01 2A 02 0B 04 01 02 03 04 00 00 00 04 02 0F
01 2A 01 02 02 C3 3C 00 00 01 00 00 02 02 0F
01 15 01 03 02 DE AD 00 00 01 00 00 00 00 0F
01 2A 05 03 02 BE EF 00 00 01 00 00 00 00 0F
01 2A 04 03 02 BE EF 00 00 01 00 00 00 00 0F
09 2A 01 03 02 12 34 00 00 01 00 00 00 00 0F
01 2A 02 03 01 77 00 00 00 01 00 01 00 00 0F
01 2A 02 03 01 77 00 00 00 01 00 00 01 01 00
0D 2A 01 0B 00 00 00 00 00 01 00 00 00 01 00
01 2A 00 0B 04 F0 0F AA 55 01 02 00 04 01 00

/* files.f */
logic/usbPePkg.sv
logic/tokenCapture.sv
logic/packetTimer.sv
logic/transactionEngine.sv
logic/usbPe.sv
sim/usbPe_checker.sv
sim/usbPe_tb.sv

/* Bender.yml */
package:
  name: usbPe

sources:
  - logic/usbPePkg.sv
  - logic/tokenCapture.sv
  - logic/packetTimer.sv
  - logic/transactionEngine.sv
  - logic/usbPe.sv
  - target: test
    files:
      - sim/usbPe_checker.sv
      - sim/usbPe_tb.sv
